// File: build.f
sha512_pkg.sv
sha512_regs_pkg.sv
sha512_core_if.sv
sha512_core.sv
sha512_intr.sv
sha512_reg_if.sv
sha512_top.sv
sha512_assert.sv
tb_sha512.sv

// File: Bender.yml
package:
  name: sha512_accel

sources:
  - sha512_pkg.sv
  - sha512_regs_pkg.sv
  - sha512_core_if.sv
  - sha512_core.sv
  - sha512_intr.sv
  - sha512_reg_if.sv
  - sha512_top.sv
  - target: test
    files:
      - sha512_assert.sv
      - tb_sha512.sv

// File: tb_sha512.sv
// Testbench with clock, bus tasks, reference model, digest comparison and watchdog
`timescale 1ns/1ps

module tb_sha512;

  localparam int          ADDR_WIDTH = 12;
  localparam int          CLK_PERIOD = 100;
  localparam int          N_HASHES   = 4;
  localparam int          MAX_POLLS  = 200;
  localparam longint      TIMEOUT_NS = (N_HASHES * 200 + 400) * CLK_PERIOD;
  localparam int unsigned SEED       = 32'he9b1;

  // CTRL command words
  localparam sha512_pkg::word_t CMD_INIT_512 = (64'd1 << sha512_regs_pkg::CTRL_INIT_BIT)
                                             | (64'd1 << sha512_regs_pkg::CTRL_MODE_BIT);
  localparam sha512_pkg::word_t CMD_NEXT_512 = (64'd1 << sha512_regs_pkg::CTRL_NEXT_BIT)
                                             | (64'd1 << sha512_regs_pkg::CTRL_MODE_BIT);
  localparam sha512_pkg::word_t CMD_INIT_384 = (64'd1 << sha512_regs_pkg::CTRL_INIT_BIT);
  // Both interrupt bits
  localparam sha512_pkg::word_t INTR_BOTH = (64'd1 << sha512_regs_pkg::INTR_ERROR_BIT)
                                          | (64'd1 << sha512_regs_pkg::INTR_NOTIF_BIT);

  logic                  clk;
  logic                  reset_n;
  logic                  cs;
  logic                  we;
  logic [ADDR_WIDTH-1:0] address;
  sha512_pkg::word_t     write_data;
  sha512_pkg::word_t     read_data;
  logic                  err;
  logic                  error_intr;
  logic                  notif_intr;

  int n_checks     = 0;
  int n_errors     = 0;
  int n_err_access = 0;

  // Digest words waiting for the comparing process
  sha512_pkg::word_t got_q [$];
  sha512_pkg::word_t exp_q [$];
  string             msg_q [$];

  sha512_top #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) DUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  bind sha512_core sha512_assert u_assert (
    .clk          (clk),
    .reset_n      (reset_n),
    .state        (state_q),
    .init         (bus.init),
    .next         (bus.next),
    .ready        (bus.ready),
    .digest_valid (bus.digest_valid)
  );

  initial
  begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0t", $time);
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Checking and reference model
  // --------------------------------------------------
  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string msg);
    n_checks++;
    if (actual !== expected)
    begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  function automatic sha512_pkg::word_t rotr(input sha512_pkg::word_t x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // One SHA-512 compression of a block onto a hash state
  function automatic sha512_pkg::digest_t ref_compress(input sha512_pkg::digest_t h_in,
                                                       input sha512_pkg::block_t blk);
    sha512_pkg::word_t   w [80];
    sha512_pkg::word_t   v [8];
    sha512_pkg::word_t   s0;
    sha512_pkg::word_t   s1;
    sha512_pkg::word_t   t1;
    sha512_pkg::word_t   t2;
    sha512_pkg::digest_t h_out;
    for (int t = 0; t < 16; t++)
      w[t] = blk[1023 - 64*t -: 64];
    // Message schedule expansion
    for (int t = 16; t < 80; t++)
    begin
      s0   = rotr(w[t-15], 1) ^ rotr(w[t-15], 8) ^ (w[t-15] >> 7);
      s1   = rotr(w[t-2], 19) ^ rotr(w[t-2], 61) ^ (w[t-2] >> 6);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
    end
    for (int i = 0; i < 8; i++)
      v[i] = h_in[511 - 64*i -: 64];
    for (int t = 0; t < 80; t++)
    begin
      t1 = v[7] + (rotr(v[4], 14) ^ rotr(v[4], 18) ^ rotr(v[4], 41))
           + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha512_pkg::K[t] + w[t];
      t2 = (rotr(v[0], 28) ^ rotr(v[0], 34) ^ rotr(v[0], 39))
           + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      v[7] = v[6];
      v[6] = v[5];
      v[5] = v[4];
      v[4] = v[3] + t1;
      v[3] = v[2];
      v[2] = v[1];
      v[1] = v[0];
      v[0] = t1 + t2;
    end
    // Feed-forward addition
    for (int i = 0; i < 8; i++)
      h_out[511 - 64*i -: 64] = h_in[511 - 64*i -: 64] + v[i];
    return h_out;
  endfunction

  function automatic sha512_pkg::block_t random_block();
    sha512_pkg::block_t blk;
    for (int i = 0; i < 32; i++)
      blk[32*i +: 32] = $urandom();
    return blk;
  endfunction

  // Digest words queued by the stimulus are compared here
  always @(negedge clk)
  begin : compare_digest
    while (got_q.size() > 0)
      check_eq(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
  end

  // --------------------------------------------------
  // Bus tasks
  // --------------------------------------------------
  // Drive on the falling edge, sample mid-cycle, release on the next falling edge
  task automatic bus_write(input int unsigned addr, input sha512_pkg::word_t data,
                           input bit exp_err);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr[ADDR_WIDTH-1:0];
    write_data = data;
    #(CLK_PERIOD / 4);
    check_eq(err, exp_err, $sformatf("err on write to %h", addr));
    n_err_access += exp_err;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input int unsigned addr, input bit exp_err,
                          output sha512_pkg::word_t data);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr[ADDR_WIDTH-1:0];
    #(CLK_PERIOD / 4);
    data = read_data;
    check_eq(err, exp_err, $sformatf("err on read of %h", addr));
    n_err_access += exp_err;
    @(negedge clk);
    cs = 1'b0;
  endtask

  task automatic write_block(input sha512_pkg::block_t blk);
    for (int i = 0; i < 16; i++)
      bus_write(sha512_regs_pkg::ADDR_BLOCK_START + 8*i, blk[1023 - 64*i -: 64], 1'b0);
  endtask

  // Wait for valid to drop after the command, then to rise again
  task automatic wait_digest();
    sha512_pkg::word_t st;
    int                polls;
    bit                seen_busy;
    st        = '0;
    polls     = 0;
    seen_busy = 1'b0;
    while ((polls < MAX_POLLS) && !(seen_busy && st[sha512_regs_pkg::STATUS_VALID_BIT]))
    begin
      bus_read(sha512_regs_pkg::ADDR_STATUS, 1'b0, st);
      if (!st[sha512_regs_pkg::STATUS_VALID_BIT])
        seen_busy = 1'b1;
      polls++;
    end
    if (!(seen_busy && st[sha512_regs_pkg::STATUS_VALID_BIT]))
    begin
      n_errors++;
      $display("Error at %0t: digest never became valid", $time);
    end
  endtask

  task automatic run_hash(input sha512_pkg::block_t blk, input sha512_pkg::word_t cmd);
    write_block(blk);
    bus_write(sha512_regs_pkg::ADDR_CTRL, cmd, 1'b0);
    wait_digest();
  endtask

  // Word 0 of the digest is the most significant word
  task automatic read_digest(input sha512_pkg::digest_t exp, input string label);
    sha512_pkg::word_t rd;
    for (int i = 0; i < 8; i++)
    begin
      bus_read(sha512_regs_pkg::ADDR_DIGEST_START + 8*i, 1'b0, rd);
      got_q.push_back(rd);
      exp_q.push_back(exp[511 - 64*i -: 64]);
      msg_q.push_back($sformatf("%s digest word %0d", label, i));
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial
  begin : stimulus
    sha512_pkg::block_t  blk;
    sha512_pkg::digest_t h;
    sha512_pkg::word_t   rd;
    void'($urandom(SEED));
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    reset_n    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Identity, reset state and block readback
    bus_read(sha512_regs_pkg::ADDR_NAME, 1'b0, rd);
    check_eq(rd, sha512_regs_pkg::CORE_NAME, "NAME");
    bus_read(sha512_regs_pkg::ADDR_VERSION, 1'b0, rd);
    check_eq(rd, sha512_regs_pkg::CORE_VERSION, "VERSION");
    bus_read(sha512_regs_pkg::ADDR_STATUS, 1'b0, rd);
    check_eq(rd, 64'd1 << sha512_regs_pkg::STATUS_READY_BIT, "STATUS after reset");
    blk = random_block();
    write_block(blk);
    for (int i = 0; i < 16; i++)
    begin
      bus_read(sha512_regs_pkg::ADDR_BLOCK_START + 8*i, 1'b0, rd);
      check_eq(rd, blk[1023 - 64*i -: 64], $sformatf("block word %0d readback", i));
    end

    // Single block, chained block, then a fresh init
    blk = random_block();
    h   = ref_compress(sha512_pkg::IV_512, blk);
    run_hash(blk, CMD_INIT_512);
    read_digest(h, "SHA-512 init");
    blk = random_block();
    h   = ref_compress(h, blk);
    run_hash(blk, CMD_NEXT_512);
    read_digest(h, "SHA-512 next");
    blk = random_block();
    h   = ref_compress(sha512_pkg::IV_512, blk);
    run_hash(blk, CMD_INIT_512);
    read_digest(h, "SHA-512 restart");

    // Bus errors with interrupts still disabled
    bus_read(32'h020, 1'b1, rd);
    bus_read(32'h300, 1'b1, rd);
    bus_read(sha512_regs_pkg::ADDR_BLOCK_START + 4, 1'b1, rd);
    bus_write(sha512_regs_pkg::ADDR_STATUS, 64'd0, 1'b1);
    bus_write(sha512_regs_pkg::ADDR_DIGEST_START, 64'd0, 1'b1);
    bus_read(sha512_regs_pkg::ADDR_INTR_STATUS, 1'b0, rd);
    check_eq(rd, INTR_BOTH, "interrupt status after errors and hashes");
    check_eq(error_intr, 1'b0, "error_intr while disabled");
    check_eq(notif_intr, 1'b0, "notif_intr while disabled");

    // Enable, then clear by writing ones
    bus_write(sha512_regs_pkg::ADDR_INTR_ENABLE, INTR_BOTH, 1'b0);
    check_eq(error_intr, 1'b1, "error_intr once enabled");
    check_eq(notif_intr, 1'b1, "notif_intr once enabled");
    bus_write(sha512_regs_pkg::ADDR_INTR_STATUS, INTR_BOTH, 1'b0);
    check_eq(error_intr, 1'b0, "error_intr after clear");
    check_eq(notif_intr, 1'b0, "notif_intr after clear");
    bus_read(sha512_regs_pkg::ADDR_INTR_STATUS, 1'b0, rd);
    check_eq(rd, 64'd0, "interrupt status after clear");

    // SHA-384 keeps words 0 to 5 and reads words 6 and 7 as zero
    blk = random_block();
    h   = ref_compress(sha512_pkg::IV_384, blk);
    run_hash(blk, CMD_INIT_384);
    read_digest({h[511:128], 128'd0}, "SHA-384");
    check_eq(notif_intr, 1'b1, "notif_intr after enabled hash");
    check_eq(error_intr, 1'b0, "error_intr after enabled hash");

    // Event counters
    bus_read(sha512_regs_pkg::ADDR_NOTIF_COUNT, 1'b0, rd);
    check_eq(rd, N_HASHES, "NOTIF_COUNT");
    bus_read(sha512_regs_pkg::ADDR_ERROR_COUNT, 1'b0, rd);
    check_eq(rd, n_err_access, "ERROR_COUNT");

    // Let the comparing process drain its queue
    repeat (2) @(negedge clk);
    #1;
    n_errors += DUT.u_core.u_assert.fail_count;
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: sha512_assert.sv
// Concurrent assertions on the round core FSM and its command and status signals
`timescale 1ns/1ps

module sha512_assert (
  input logic                    clk,
  input logic                    reset_n,
  input sha512_pkg::core_state_t state,
  input logic                    init,
  input logic                    next,
  input logic                    ready,
  input logic                    digest_valid
);

  // Count of failed assertions
  int fail_count = 0;

  // --------------------------------------------------
  // Command acceptance
  // --------------------------------------------------
  // Rounds start only from IDLE and only on a command
  a_start_from_idle : assert property (@(posedge clk) disable iff (!reset_n)
    (state == sha512_pkg::CORE_ROUND) && ($past(state) != sha512_pkg::CORE_ROUND)
    |-> ($past(state) == sha512_pkg::CORE_IDLE) && $past(init || next))
    else
    begin
      fail_count++;
      $error("Core entered rounds without a command in IDLE");
    end

  // --------------------------------------------------
  // Status levels
  // --------------------------------------------------
  a_ready_level : assert property (@(posedge clk) disable iff (!reset_n)
    ready == (state != sha512_pkg::CORE_ROUND))
    else
    begin
      fail_count++;
      $error("ready does not match the round state");
    end

  a_valid_not_busy : assert property (@(posedge clk) disable iff (!reset_n)
    !(digest_valid && (state == sha512_pkg::CORE_ROUND)))
    else
    begin
      fail_count++;
      $error("digest_valid high while rounds run");
    end

endmodule

// File: sha512_top.sv
// SHA-512 accelerator top level joining front end, round core and interrupt block
`timescale 1ns/1ps

module sha512_top #(
  parameter int ADDR_WIDTH = 12
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cs,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] address,
  input  sha512_pkg::word_t     write_data,
  output sha512_pkg::word_t     read_data,
  output logic                  err,
  output logic                  error_intr,
  output logic                  notif_intr
);

  // Front end to interrupt block
  logic              done_pulse;
  logic              err_pulse;
  logic              intr_wr;
  logic [1:0]        intr_sel;
  sha512_pkg::word_t intr_rd_data;

  // Command and digest path to the core
  sha512_core_if core_bus ();

  sha512_reg_if #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_reg_if (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .intr_rd_data (intr_rd_data),
    .read_data    (read_data),
    .err          (err),
    .done_pulse   (done_pulse),
    .err_pulse    (err_pulse),
    .intr_wr      (intr_wr),
    .intr_sel     (intr_sel),
    .core         (core_bus)
  );

  sha512_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (core_bus)
  );

  sha512_intr u_intr (
    .clk        (clk),
    .reset_n    (reset_n),
    .done_pulse (done_pulse),
    .err_pulse  (err_pulse),
    .intr_wr    (intr_wr),
    .intr_sel   (intr_sel),
    .write_data (write_data),
    .rd_data    (intr_rd_data),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

endmodule

// File: sha512_reg_if.sv
// Register front end with address decode, block, control, status and digest registers
`timescale 1ns/1ps

module sha512_reg_if #(
  parameter int ADDR_WIDTH = 12
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cs,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] address,
  input  sha512_pkg::word_t     write_data,
  input  sha512_pkg::word_t     intr_rd_data,
  output sha512_pkg::word_t     read_data,
  output logic                  err,
  output logic                  done_pulse,
  output logic                  err_pulse,
  output logic                  intr_wr,
  output logic [1:0]            intr_sel,
  sha512_core_if.ctrl           core
);

  // Block words and digest copy
  sha512_pkg::word_t   block_q [16];
  sha512_pkg::digest_t digest_q;

  // Command pulses, mode and registered core status
  logic init_q;
  logic next_q;
  logic mode_q;
  logic ready_q;
  logic valid_q;

  // Decode
  logic              aligned;
  logic              block_hit;
  logic              digest_hit;
  logic              intr_hit;
  logic              hit;
  logic              writable;
  logic              wr_ok;
  logic              ctrl_we;
  logic              block_we;
  logic [3:0]        blk_idx;
  logic [2:0]        dig_idx;
  sha512_pkg::word_t rd_word;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // Only 8-byte aligned addresses select a register
  assign aligned    = (address[2:0] == 3'b000);
  assign block_hit  = aligned && (address >= sha512_regs_pkg::ADDR_BLOCK_START)
                      && (address <= sha512_regs_pkg::ADDR_BLOCK_END);
  assign digest_hit = aligned && (address >= sha512_regs_pkg::ADDR_DIGEST_START)
                      && (address <= sha512_regs_pkg::ADDR_DIGEST_END);
  assign intr_hit   = aligned && (address >= sha512_regs_pkg::ADDR_INTR_STATUS)
                      && (address <= sha512_regs_pkg::ADDR_ERROR_COUNT);
  assign blk_idx    = address[6:3];
  assign dig_idx    = address[5:3];

  always_comb
  begin : decode
    hit      = 1'b1;
    writable = 1'b0;
    rd_word  = '0;
    if (block_hit)
    begin
      writable = 1'b1;
      rd_word  = block_q[blk_idx];
    end
    else if (digest_hit)
    begin
      rd_word = digest_q[(7 - dig_idx) * 64 +: 64];
      // SHA-384 keeps only words 0 to 5
      if ((mode_q == sha512_pkg::MODE_SHA_384) && (dig_idx >= 3'd6))
        rd_word = '0;
    end
    else if (intr_hit)
    begin
      // Status and enable take writes, the counters are read-only
      writable = (address == sha512_regs_pkg::ADDR_INTR_STATUS)
                 || (address == sha512_regs_pkg::ADDR_INTR_ENABLE);
      rd_word  = intr_rd_data;
    end
    else
    begin
      case (address)
        sha512_regs_pkg::ADDR_NAME:
          rd_word = sha512_regs_pkg::CORE_NAME;
        sha512_regs_pkg::ADDR_VERSION:
          rd_word = sha512_regs_pkg::CORE_VERSION;
        sha512_regs_pkg::ADDR_CTRL:
        begin
          writable = 1'b1;
          rd_word[sha512_regs_pkg::CTRL_INIT_BIT] = init_q;
          rd_word[sha512_regs_pkg::CTRL_NEXT_BIT] = next_q;
          rd_word[sha512_regs_pkg::CTRL_MODE_BIT] = mode_q;
        end
        sha512_regs_pkg::ADDR_STATUS:
        begin
          rd_word[sha512_regs_pkg::STATUS_READY_BIT] = ready_q;
          rd_word[sha512_regs_pkg::STATUS_VALID_BIT] = valid_q;
        end
        default:
          hit = 1'b0;
      endcase
    end
  end

  // Undefined address, or a write to a read-only register
  assign err       = cs && (!hit || (we && !writable));
  assign err_pulse = err;
  assign wr_ok     = cs && we && hit && writable;
  assign ctrl_we   = wr_ok && (address == sha512_regs_pkg::ADDR_CTRL);
  assign block_we  = wr_ok && block_hit;
  assign read_data = (cs && !we) ? rd_word : '0;

  // Interrupt register index counts 8-byte steps from INTR_STATUS
  assign intr_wr    = wr_ok && intr_hit;
  assign intr_sel   = 2'((address - sha512_regs_pkg::ADDR_INTR_STATUS) >> 3);
  assign done_pulse = core.digest_valid && !valid_q;

  // --------------------------------------------------
  // Core connection
  // --------------------------------------------------
  assign core.init = init_q;
  assign core.next = next_q;
  assign core.mode = mode_q;

  // Word 0 lands in the top bits of the block
  always_comb
  begin : pack_block
    for (int i = 0; i < 16; i++)
      core.block[1023 - 64*i -: 64] = block_q[i];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin : ctrl_regs
    if (!reset_n)
    begin
      init_q  <= 1'b0;
      next_q  <= 1'b0;
      mode_q  <= sha512_pkg::MODE_SHA_512;
      ready_q <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      // init and next live for one cycle after the CTRL write
      init_q  <= ctrl_we && write_data[sha512_regs_pkg::CTRL_INIT_BIT];
      next_q  <= ctrl_we && write_data[sha512_regs_pkg::CTRL_NEXT_BIT];
      if (ctrl_we)
        mode_q <= write_data[sha512_regs_pkg::CTRL_MODE_BIT];
      ready_q <= core.ready;
      valid_q <= core.digest_valid;
    end
  end

  always_ff @(posedge clk)
  begin : data_regs
    if (block_we)
      block_q[blk_idx] <= write_data;
    // Digest held from completion until the next completion
    if (done_pulse)
      digest_q <= core.digest;
  end

endmodule

// File: sha512_intr.sv
// Interrupt block with sticky status, enables, saturating event counters and interrupt outputs
`timescale 1ns/1ps

module sha512_intr (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              done_pulse,
  input  logic              err_pulse,
  input  logic              intr_wr,
  input  logic [1:0]        intr_sel,
  input  sha512_pkg::word_t write_data,
  output sha512_pkg::word_t rd_data,
  output logic              error_intr,
  output logic              notif_intr
);

  localparam int ERR = sha512_regs_pkg::INTR_ERROR_BIT;
  localparam int NTF = sha512_regs_pkg::INTR_NOTIF_BIT;

  // Register index from the address map, in 8-byte steps
  localparam int unsigned BASE = sha512_regs_pkg::ADDR_INTR_STATUS;
  localparam logic [1:0] SEL_STATUS = 2'd0;
  localparam logic [1:0] SEL_ENABLE = 2'((sha512_regs_pkg::ADDR_INTR_ENABLE - BASE) >> 3);
  localparam logic [1:0] SEL_NOTIF  = 2'((sha512_regs_pkg::ADDR_NOTIF_COUNT - BASE) >> 3);

  logic [1:0]  sts_q;
  logic [1:0]  en_q;
  logic [15:0] notif_cnt_q;
  logic [15:0] error_cnt_q;
  logic        sts_wr;
  logic        en_wr;

  // Count up and hold at all ones
  function automatic logic [15:0] sat_inc(input logic [15:0] cnt);
    sat_inc = (cnt == 16'hffff) ? cnt : cnt + 16'd1;
  endfunction

  assign sts_wr     = intr_wr && (intr_sel == SEL_STATUS);
  assign en_wr      = intr_wr && (intr_sel == SEL_ENABLE);
  assign error_intr = sts_q[ERR] && en_q[ERR];
  assign notif_intr = sts_q[NTF] && en_q[NTF];

  always_ff @(posedge clk or negedge reset_n)
  begin : intr_regs
    if (!reset_n)
    begin
      sts_q       <= '0;
      en_q        <= '0;
      notif_cnt_q <= '0;
      error_cnt_q <= '0;
    end
    else
    begin
      // Write 1 to clear, a new event in the same cycle wins
      sts_q[ERR] <= err_pulse || (sts_q[ERR] && !(sts_wr && write_data[ERR]));
      sts_q[NTF] <= done_pulse || (sts_q[NTF] && !(sts_wr && write_data[NTF]));
      if (en_wr)
      begin
        en_q[ERR] <= write_data[ERR];
        en_q[NTF] <= write_data[NTF];
      end
      if (done_pulse)
        notif_cnt_q <= sat_inc(notif_cnt_q);
      if (err_pulse)
        error_cnt_q <= sat_inc(error_cnt_q);
    end
  end

  always_comb
  begin : read_mux
    rd_data = '0;
    case (intr_sel)
      SEL_STATUS: rd_data[1:0]  = sts_q;
      SEL_ENABLE: rd_data[1:0]  = en_q;
      SEL_NOTIF:  rd_data[15:0] = notif_cnt_q;
      default:    rd_data[15:0] = error_cnt_q;
    endcase
  end

endmodule

// File: sha512_core.sv
// Iterative SHA-512 compression core with rolling message schedule and round FSM
`timescale 1ns/1ps

module sha512_core (
  input  logic        clk,
  input  logic        reset_n,
  sha512_core_if.core bus
);

  localparam sha512_pkg::round_t LAST_ROUND = 7'd79;

  // Control state
  sha512_pkg::core_state_t state_q;
  sha512_pkg::round_t      round_q;
  // High for the one cycle of final addition after round 79
  logic                    add_q;
  logic                    valid_q;

  // Schedule window, working variables a..h and hash state
  sha512_pkg::word_t   w_q [16];
  sha512_pkg::word_t   v_q [8];
  sha512_pkg::word_t   h_q [8];
  sha512_pkg::word_t   v_nxt [8];
  sha512_pkg::word_t   w_nxt;
  sha512_pkg::word_t   t1;
  sha512_pkg::word_t   t2;
  sha512_pkg::digest_t iv;
  logic                accept;

  // --------------------------------------------------
  // SHA-512 word functions
  // --------------------------------------------------
  function automatic sha512_pkg::word_t rotr(input sha512_pkg::word_t x, input int unsigned n);
    rotr = (x >> n) | (x << (64 - n));
  endfunction

  function automatic sha512_pkg::word_t big_s0(input sha512_pkg::word_t x);
    big_s0 = rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic sha512_pkg::word_t big_s1(input sha512_pkg::word_t x);
    big_s1 = rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  function automatic sha512_pkg::word_t small_s0(input sha512_pkg::word_t x);
    small_s0 = rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic sha512_pkg::word_t small_s1(input sha512_pkg::word_t x);
    small_s1 = rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // Commands count only in IDLE; a pulse in ROUND or DONE is dropped
  assign accept = (state_q == sha512_pkg::CORE_IDLE) && (bus.init || bus.next);
  assign iv = (bus.mode == sha512_pkg::MODE_SHA_384) ? sha512_pkg::IV_384
                                                    : sha512_pkg::IV_512;

  // ready drops only while rounds or the final addition run
  assign bus.ready        = (state_q != sha512_pkg::CORE_ROUND);
  assign bus.digest_valid = valid_q;
  assign bus.digest       = {h_q[0], h_q[1], h_q[2], h_q[3], h_q[4], h_q[5], h_q[6], h_q[7]};

  // --------------------------------------------------
  // One round, a in v_q[0] through h in v_q[7]
  // --------------------------------------------------
  always_comb
  begin : round_logic
    // Ch(e,f,g) and Maj(a,b,c)
    t1 = v_q[7] + big_s1(v_q[4]) + ((v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]))
         + sha512_pkg::K[round_q] + w_q[0];
    t2 = big_s0(v_q[0]) + ((v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]));
    v_nxt[0] = t1 + t2;
    v_nxt[1] = v_q[0];
    v_nxt[2] = v_q[1];
    v_nxt[3] = v_q[2];
    v_nxt[4] = v_q[3] + t1;
    v_nxt[5] = v_q[4];
    v_nxt[6] = v_q[5];
    v_nxt[7] = v_q[6];
    // W[t+16] from the window, W[t] sits in slot 0
    w_nxt = small_s1(w_q[14]) + w_q[9] + small_s0(w_q[1]) + w_q[0];
  end

  // --------------------------------------------------
  // Round FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin : fsm
    if (!reset_n)
    begin
      state_q <= sha512_pkg::CORE_IDLE;
      round_q <= '0;
      add_q   <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        sha512_pkg::CORE_IDLE:
          if (accept)
          begin
            state_q <= sha512_pkg::CORE_ROUND;
            round_q <= '0;
            valid_q <= 1'b0;
          end
        sha512_pkg::CORE_ROUND:
          if (add_q)
          begin
            add_q   <= 1'b0;
            valid_q <= 1'b1;
            state_q <= sha512_pkg::CORE_DONE;
          end
          else if (round_q == LAST_ROUND)
          begin
            round_q <= '0;
            add_q   <= 1'b1;
          end
          else
          begin
            round_q <= round_q + 7'd1;
          end
        // One cycle with the final digest, then back to accepting
        default:
          state_q <= sha512_pkg::CORE_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin : datapath
    if (accept)
    begin
      // Block copied here so later bus writes do not disturb the hash
      for (int i = 0; i < 16; i++)
        w_q[i] <= bus.block[1023 - 64*i -: 64];
      for (int i = 0; i < 8; i++)
      begin
        // init restarts from the IV, next chains on the previous H
        if (bus.init)
        begin
          h_q[i] <= iv[511 - 64*i -: 64];
          v_q[i] <= iv[511 - 64*i -: 64];
        end
        else
        begin
          v_q[i] <= h_q[i];
        end
      end
    end
    else if (state_q == sha512_pkg::CORE_ROUND)
    begin
      if (add_q)
      begin
        for (int i = 0; i < 8; i++)
          h_q[i] <= h_q[i] + v_q[i];
      end
      else
      begin
        v_q <= v_nxt;
        for (int i = 0; i < 15; i++)
          w_q[i] <= w_q[i + 1];
        w_q[15] <= w_nxt;
      end
    end
  end

endmodule

// File: sha512_core_if.sv
// Command, block and digest signals between the register front end and the round core
`timescale 1ns/1ps

interface sha512_core_if;

  // Front end to core
  logic                  init;
  logic                  next;
  logic                  mode;
  sha512_pkg::block_t    block;

  // Core to front end
  logic                  ready;
  sha512_pkg::digest_t   digest;
  logic                  digest_valid;

  modport ctrl (output init, next, mode, block, input ready, digest, digest_valid);
  modport core (input init, next, mode, block, output ready, digest, digest_valid);

endinterface

// File: sha512_regs_pkg.sv
// Register addresses, control and status bit positions and identity constants
package sha512_regs_pkg;

  // Identity and control
  localparam int unsigned ADDR_NAME    = 32'h000;
  localparam int unsigned ADDR_VERSION = 32'h008;
  localparam int unsigned ADDR_CTRL    = 32'h010;
  localparam int unsigned ADDR_STATUS  = 32'h018;

  // Sixteen block words and eight digest words, 8 bytes apart
  localparam int unsigned ADDR_BLOCK_START  = 32'h080;
  localparam int unsigned ADDR_BLOCK_END    = 32'h0f8;
  localparam int unsigned ADDR_DIGEST_START = 32'h100;
  localparam int unsigned ADDR_DIGEST_END   = 32'h138;

  // Interrupt block
  localparam int unsigned ADDR_INTR_STATUS = 32'h200;
  localparam int unsigned ADDR_INTR_ENABLE = 32'h208;
  localparam int unsigned ADDR_NOTIF_COUNT = 32'h210;
  localparam int unsigned ADDR_ERROR_COUNT = 32'h218;

  // Bit positions
  localparam int CTRL_INIT_BIT    = 0;
  localparam int CTRL_NEXT_BIT    = 1;
  localparam int CTRL_MODE_BIT    = 2;
  localparam int STATUS_READY_BIT = 0;
  localparam int STATUS_VALID_BIT = 1;
  localparam int INTR_ERROR_BIT   = 0;
  localparam int INTR_NOTIF_BIT   = 1;

  // ASCII identity words
  localparam sha512_pkg::word_t CORE_NAME    = "sha2-512";
  localparam sha512_pkg::word_t CORE_VERSION = "1.00";

endpackage

// File: sha512_pkg.sv
// SHA-512 word, block and digest types, round constants, initial values, mode bit and core states
package sha512_pkg;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  // One hash word
  typedef logic [63:0] word_t;
  // Pre-padded message block, word 0 in the top bits
  typedef logic [1023:0] block_t;
  // Eight-word hash state, H0 in the top bits
  typedef logic [511:0] digest_t;
  // Round index, 0 to 79
  typedef logic [6:0] round_t;

  // Single mode bit
  localparam logic MODE_SHA_384 = 1'b0;
  localparam logic MODE_SHA_512 = 1'b1;

  // Compression core FSM
  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ROUND,
    CORE_DONE
  } core_state_t;

  // --------------------------------------------------
  // Round constants and initial hash values
  // --------------------------------------------------
  localparam word_t K [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // SHA-512 start state
  localparam digest_t IV_512 = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  // SHA-384 start state, same compression with a different IV
  localparam digest_t IV_384 = {
    64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
    64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
  };

endpackage
